// File: dv/lsu_tb.sv
// Testbench for the load/store unit with a table of accesses and a memory mirror
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    typedef enum {k_wb, k_store, k_mis, k_none} kind_e;
    typedef struct {
        string       name;
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        kind_e       kind;
    } entry_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic issue = 1'b0;
    logic [31:0] instr = 32'd0, rs1_data = 32'd0, rs2_data = 32'd0;
    logic issue_ready, mem_read_en, mem_write_en, mem_read_ready, mem_write_ready;
    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic [3:0]  mem_strb;
    wb_t  wb;
    logic wb_en, misalign;
    logic log_valid;
    logic [31:0] log_addr, log_data;
    logic [3:0]  log_strb;

    entry_t      table_q[$];
    logic [7:0]  mirror [0:255];
    wb_t         exp_wb_q[$];
    logic [31:0] exp_addr_q[$], exp_data_q[$];
    logic [3:0]  exp_strb_q[$];
    string       wb_name_q[$], st_name_q[$], mis_name_q[$];
    logic        running = 1'b0;
    integer      i;

    always #20 clk = ~clk;                         // 40 ns period

    lsu_top i_dut (
        .clk, .rst, .issue, .instr, .rs1_data, .rs2_data, .issue_ready,
        .mem_addr, .mem_wdata, .mem_strb, .mem_read_en, .mem_write_en,
        .mem_rdata, .mem_read_ready, .mem_write_ready, .wb, .wb_en, .misalign
    );

    lsu_tb_mem i_mem (
        .clk, .rst, .addr (mem_addr), .wdata (mem_wdata), .strb (mem_strb),
        .read_en (mem_read_en), .write_en (mem_write_en), .rdata (mem_rdata),
        .read_ready (mem_read_ready), .write_ready (mem_write_ready),
        .log_valid, .log_addr, .log_strb, .log_data
    );

    function automatic logic [31:0] enc_load(logic [2:0] f3, logic [4:0] rd, logic [11:0] imm);
        return {imm, 5'd1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_store(logic [2:0] f3, logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    task automatic add(string name, logic [31:0] ins, logic [31:0] r1, logic [31:0] r2,
                       kind_e kind);
        entry_t e;
        e.name  = name;
        e.instr = ins;
        e.rs1   = r1;
        e.rs2   = r2;
        e.kind  = kind;
        table_q.push_back(e);
    endtask

    // Expected results straight from the RV32I load/store rules
    task automatic expect_entry(entry_t e);
        logic [31:0] imm, addr, word, mask;
        logic [7:0]  a;
        logic [3:0]  strb;
        imm  = (e.kind == k_store) ? {{20{e.instr[31]}}, e.instr[31:25], e.instr[11:7]}
                                   : {{20{e.instr[31]}}, e.instr[31:20]};
        addr = e.rs1 + imm;
        a    = addr[7:0];
        word = {mirror[a + 8'd3], mirror[a + 8'd2], mirror[a + 8'd1], mirror[a]};
        case (e.kind)
            k_wb: begin
                case (e.instr[14:12])
                    3'b000:  word = {{24{word[7]}}, word[7:0]};
                    3'b100:  word = {24'd0, word[7:0]};
                    3'b001:  word = {{16{word[15]}}, word[15:0]};
                    3'b101:  word = {16'd0, word[15:0]};
                    default: word = word;
                endcase
                exp_wb_q.push_back('{rd: e.instr[11:7], data: word});
                wb_name_q.push_back(e.name);
            end
            k_store: begin
                strb = (e.instr[14:12] == 3'b000) ? 4'b0001 << a[1:0] :
                       (e.instr[14:12] == 3'b001) ? 4'b0011 << a[1:0] : 4'b1111;
                mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
                word = (e.rs2 << (8 * a[1:0])) & mask;
                for (int k = 0; k < 4; k++) begin
                    if (strb[k]) mirror[{a[7:2], 2'b00} + k] = word[8*k +: 8];
                end
                exp_addr_q.push_back(addr);
                exp_strb_q.push_back(strb);
                exp_data_q.push_back(word);
                st_name_q.push_back(e.name);
            end
            k_mis:   mis_name_q.push_back(e.name);
            default: ;                             // Dropped by the decoder
        endcase
    endtask

    task automatic fail_now(string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic check_wb(string name, wb_t exp, wb_t act);
        if (exp !== act)
            fail_now($sformatf("** Error %s: expected rd %0d data %h, actual rd %0d data %h",
                               name, exp.rd, exp.data, act.rd, act.data));
    endtask

    task automatic check_store(string name, logic [xlen-1:0] ea, logic [3:0] es,
                               logic [xlen-1:0] ed, logic [xlen-1:0] aa, logic [3:0] as,
                               logic [xlen-1:0] ad);
        if (ea !== aa || es !== as || ed !== ad)
            fail_now($sformatf("** Error %s: expected %h/%b/%h, actual %h/%b/%h",
                               name, ea, es, ed, aa, as, ad));
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act)
            fail_now($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    endtask

    // Every result must match the next expected one of its kind, in table order
    always @(posedge clk) begin
        if (running && wb_en) begin
            if (exp_wb_q.size() == 0) fail_now("Unexpected writeback seen on wb");
            else check_wb(wb_name_q.pop_front(), exp_wb_q.pop_front(), wb);
        end
        if (running && log_valid) begin
            if (exp_addr_q.size() == 0) fail_now("Unexpected store reached memory");
            else check_store(st_name_q.pop_front(), exp_addr_q.pop_front(),
                             exp_strb_q.pop_front(), exp_data_q.pop_front(),
                             log_addr, log_strb, log_data);
        end
        if (running && misalign) begin
            if (mis_name_q.size() == 0) fail_now("Unexpected misalign pulse");
            else check_flag(mis_name_q.pop_front(), 1'b0, mem_read_en || mem_write_en);
        end
    end

    initial begin
        wait (running);
        repeat (table_q.size() * 12 + 16) @(posedge clk);
        $display("Test failures found");
        $fatal(1, "Watchdog: the tests did not finish in time");
    end

    initial begin
        for (i = 0; i < 256; i++) mirror[i] = 8'((i * 59) ^ (i >> 4) ^ 8'h96);
        add("lw_0",     enc_load(3'b010, 5'd1, 12'h000), 32'h40, 0, k_wb);
        add("lw_neg",   enc_load(3'b010, 5'd2, 12'hffc), 32'h50, 0, k_wb);
        add("lh_0",     enc_load(3'b001, 5'd3, 12'h000), 32'h44, 0, k_wb);
        add("lh_2",     enc_load(3'b001, 5'd4, 12'h002), 32'h44, 0, k_wb);
        add("lhu_0",    enc_load(3'b101, 5'd5, 12'h000), 32'h48, 0, k_wb);
        add("lhu_2",    enc_load(3'b101, 5'd6, 12'hffe), 32'h4c, 0, k_wb);
        for (i = 0; i < 4; i++) begin
            add($sformatf("lb_%0d", i),  enc_load(3'b000, 5'(7 + i), 12'(i)), 32'h5c, 0, k_wb);
            add($sformatf("lbu_%0d", i), enc_load(3'b100, 5'(11 + i), 12'hfff), 32'h61 + i,
                0, k_wb);
        end
        add("sw",       enc_store(3'b010, 12'h000), 32'h80, 32'hdead_beef, k_store);
        add("lw_sw",    enc_load(3'b010, 5'd15, 12'h000), 32'h80, 0, k_wb);
        add("sh_2",     enc_store(3'b001, 12'h006), 32'h80, 32'h1234_f00d, k_store);
        add("lh_sh",    enc_load(3'b001, 5'd16, 12'h006), 32'h80, 0, k_wb);
        add("lhu_sh",   enc_load(3'b101, 5'd17, 12'h002), 32'h84, 0, k_wb);
        add("sb_1",     enc_store(3'b000, 12'hfff), 32'h8a, 32'h0000_00a7, k_store);
        add("lb_sb",    enc_load(3'b000, 5'd18, 12'h009), 32'h80, 0, k_wb);
        add("lbu_sb",   enc_load(3'b100, 5'd19, 12'h001), 32'h88, 0, k_wb);
        add("lw_sb",    enc_load(3'b010, 5'd20, 12'h008), 32'h80, 0, k_wb);
        add("lh_odd",   enc_load(3'b001, 5'd21, 12'h001), 32'h40, 0, k_mis);
        add("lw_unal",  enc_load(3'b010, 5'd22, 12'h002), 32'h40, 0, k_mis);
        add("sw_unal",  enc_store(3'b010, 12'h003), 32'h80, 32'h5555_aaaa, k_mis);
        add("sh_odd",   enc_store(3'b001, 12'h003), 32'h80, 32'h0000_7777, k_mis);
        add("addi",     32'h0010_0093, 32'h40, 0, k_none);
        add("ld_rsvd",  enc_load(3'b110, 5'd23, 12'h000), 32'h40, 0, k_none);
        add("lw_last",  enc_load(3'b010, 5'd24, 12'h004), 32'h80, 0, k_wb);
        foreach (table_q[n]) expect_entry(table_q[n]);

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("reset_read_en", 1'b0, mem_read_en);
        check_flag("reset_write_en", 1'b0, mem_write_en);
        check_flag("reset_wb_en", 1'b0, wb_en);
        check_flag("reset_misalign", 1'b0, misalign);
        check_flag("reset_issue_ready", 1'b1, issue_ready);
        running = 1'b1;

        foreach (table_q[n]) begin
            issue    <= 1'b1;
            instr    <= table_q[n].instr;
            rs1_data <= table_q[n].rs1;
            rs2_data <= table_q[n].rs2;
            do @(posedge clk); while (!issue_ready);   // Taken on an edge with ready high
        end
        issue <= 1'b0;
        while (exp_wb_q.size() != 0 || exp_addr_q.size() != 0 || mis_name_q.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);                 // Room for any extra result to show up
        if (!mem_read_en && !mem_write_en) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Bus still busy after the last expected result");
            $display("Test failures found");
            $fatal(1, "Bus enable left high");
        end
    end

endmodule

`default_nettype wire

// File: dv/lsu_tb_mem.sv
// Data memory model with seeded random ready delay and a log of every store
`timescale 1ns/100ps
`default_nettype none

module lsu_tb_mem (
    input  wire         clk,
    input  wire         rst,
    input  wire  [31:0] addr,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  strb,
    input  wire         read_en,
    input  wire         write_en,
    output logic [31:0] rdata,
    output logic        read_ready,
    output logic        write_ready,
    output logic        log_valid,                 // One pulse per completed store
    output logic [31:0] log_addr,
    output logic [3:0]  log_strb,
    output logic [31:0] log_data                   // Unstrobed bytes forced to zero
);

    logic [7:0]  mem [0:255];
    logic [7:0]  base;
    logic [31:0] mask;
    logic        active;
    integer      seed;
    integer      count;
    integer      k;

    assign base = {addr[7:2], 2'b00};
    assign mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};

    initial begin
        seed = 32'h1c55_fa30;
        for (k = 0; k < 256; k = k + 1) begin
            mem[k] = 8'((k * 59) ^ (k >> 4) ^ 8'h96); // Depends on all address bits
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            read_ready  <= 1'b0;
            write_ready <= 1'b0;
            log_valid   <= 1'b0;
            active      <= 1'b0;
            count       <= 0;
            rdata       <= 32'd0;
        end else begin
            read_ready  <= 1'b0;
            write_ready <= 1'b0;
            log_valid   <= 1'b0;
            if (active) begin
                if (count == 0) begin
                    active <= 1'b0;
                    if (read_en) begin
                        read_ready <= 1'b1;
                        rdata <= {mem[base + 8'd3], mem[base + 8'd2],
                                  mem[base + 8'd1], mem[base]};
                    end else begin
                        write_ready <= 1'b1;
                        for (k = 0; k < 4; k = k + 1) begin
                            if (strb[k]) mem[base + k] <= wdata[8*k +: 8];
                        end
                        log_valid <= 1'b1;
                        log_addr  <= addr;
                        log_strb  <= strb;
                        log_data  <= wdata & mask;
                    end
                end else begin
                    count <= count - 1;
                end
            end else if ((read_en || write_en) && !read_ready && !write_ready) begin
                active <= 1'b1;                    // New access, pick its delay
                count  <= ($random(seed) & 32'h7fff_ffff) % 6;
            end
        end
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/lsu_pkg.sv
hdl/ls_stage_reg.sv
hdl/ls_decode.sv
hdl/ls_agen.sv
hdl/ls_mem_ctrl.sv
hdl/ls_load_format.sv
hdl/lsu_top.sv
dv/lsu_tb_mem.sv
dv/lsu_tb.sv

// File: hdl/ls_agen.sv
// Address stage computing effective address, byte strobes, store lanes and alignment
`timescale 1ns/100ps
`default_nettype none

module ls_agen (
    input  lsu_pkg::dec_t  dec,
    output lsu_pkg::agen_t agen,
    output logic           misaligned
);
    import lsu_pkg::*;

    logic [xlen-1:0] addr;
    logic [1:0]      offset;
    ls_size_e        size;

    assign addr   = dec.rs1_data + dec.imm;
    assign offset = addr[1:0];

    always_comb begin
        case (dec.op)
            op_lb, op_lbu, op_sb: size = size_byte;
            op_lh, op_lhu, op_sh: size = size_half;
            default:              size = size_word;
        endcase
    end

    assign misaligned = ((size == size_half) && offset[0]) ||
                        ((size == size_word) && (offset != 2'b00));

    always_comb begin
        agen.op         = dec.op;
        agen.rd         = dec.rd;
        agen.addr       = addr;
        agen.misaligned = misaligned;
        case (size)
            size_byte: begin
                agen.strb  = 4'b0001 << offset;
                agen.wdata = {24'd0, dec.rs2_data[7:0]} << {offset, 3'b000};
            end
            size_half: begin
                agen.strb  = 4'b0011 << offset;    // Upper lane falls off when misaligned
                agen.wdata = {16'd0, dec.rs2_data[15:0]} << {offset, 3'b000};
            end
            default: begin
                agen.strb  = 4'b1111;
                agen.wdata = dec.rs2_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ls_decode.sv
// Load/store decoder mapping opcode and funct3 to an operation with its immediate
`timescale 1ns/100ps
`default_nettype none

module ls_decode (
    input  wire [lsu_pkg::xlen-1:0] instr,
    input  wire [lsu_pkg::xlen-1:0] rs1_data,
    input  wire [lsu_pkg::xlen-1:0] rs2_data,
    input  wire                     issue,
    output lsu_pkg::dec_t           dec,
    output logic                    dec_valid
);
    import lsu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    ls_op_e          op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        op = op_none;
        if (opcode == opcode_load) begin
            case (funct3)
                f3_b:    op = op_lb;
                f3_bu:   op = op_lbu;
                f3_h:    op = op_lh;
                f3_hu:   op = op_lhu;
                f3_w:    op = op_lw;
                default: op = op_none;             // Reserved load widths
            endcase
        end else if (opcode == opcode_store) begin
            case (funct3)
                f3_b:    op = op_sb;
                f3_h:    op = op_sh;
                f3_w:    op = op_sw;
                default: op = op_none;
            endcase
        end
    end

    always_comb begin
        dec.op       = op;
        dec.rd       = (opcode == opcode_load) ? instr[11:7] : 5'd0; // Stores carry imm there
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.imm      = (opcode == opcode_store) ? imm_s : imm_i;
    end

    // Unknown instructions never enter the pipeline
    assign dec_valid = issue && (op != op_none);

endmodule

`default_nettype wire

// File: hdl/ls_load_format.sv
// Load formatter selecting the addressed lane and extending it for writeback
`timescale 1ns/100ps
`default_nettype none

module ls_load_format (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      load_done,
    input  lsu_pkg::ls_op_e          load_op,
    input  wire [4:0]                load_rd,
    input  wire [1:0]                load_offset,
    input  wire [lsu_pkg::xlen-1:0]  mem_rdata,
    input  wire                      mem_read_ready,
    output lsu_pkg::wb_t             wb,
    output logic                     wb_en
);
    import lsu_pkg::*;

    logic [xlen-1:0] rdata_q;
    logic [xlen-1:0] lane;
    logic [xlen-1:0] ext;

    always_ff @(posedge clk) begin
        if (mem_read_ready) begin
            rdata_q <= mem_rdata;                  // Valid only in the ready cycle
        end
    end

    assign lane = rdata_q >> {load_offset, 3'b000};    // Addressed lane down to bit 0

    always_comb begin
        case (load_op)
            op_lb:   ext = {{24{lane[7]}}, lane[7:0]};
            op_lbu:  ext = {24'd0, lane[7:0]};
            op_lh:   ext = {{16{lane[15]}}, lane[15:0]};
            op_lhu:  ext = {16'd0, lane[15:0]};
            default: ext = rdata_q;                // LW
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= load_done;
        end
    end

    always_ff @(posedge clk) begin
        if (load_done) begin
            wb.rd   <= load_rd;
            wb.data <= ext;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ls_mem_ctrl.sv
// Memory controller FSM running one access at a time on the data bus
`timescale 1ns/100ps
`default_nettype none

module ls_mem_ctrl (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req_valid,
    input  lsu_pkg::agen_t              req,
    input  wire                         req_misaligned,
    output logic                        accept,
    output logic [lsu_pkg::xlen-1:0]    mem_addr,
    output logic [lsu_pkg::xlen-1:0]    mem_wdata,
    output logic [lsu_pkg::xlen/8-1:0]  mem_strb,
    output logic                        mem_read_en,
    output logic                        mem_write_en,
    input  wire                         mem_read_ready,
    input  wire                         mem_write_ready,
    output logic                        load_done,
    output lsu_pkg::ls_op_e             load_op,
    output logic [4:0]                  load_rd,
    output logic [1:0]                  load_offset,
    output logic                        misalign
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_read  = 2'b01,
        st_write = 2'b10
    } state_e;

    state_e state;
    logic   is_load;
    logic   is_store;
    logic   start;

    assign accept   = (state == st_idle) && req_valid;  // Only IDLE takes an item
    assign is_load  = req.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw};
    assign is_store = req.op inside {op_sb, op_sh, op_sw};
    assign start    = accept && !req_misaligned;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            mem_read_en  <= 1'b0;
            mem_write_en <= 1'b0;
            load_done    <= 1'b0;
            misalign     <= 1'b0;
        end else begin
            load_done <= 1'b0;
            misalign  <= accept && req_misaligned;     // Dropped item, one pulse
            case (state)
                st_idle: begin
                    if (start && is_load) begin
                        mem_read_en <= 1'b1;
                        state       <= st_read;
                    end else if (start && is_store) begin
                        mem_write_en <= 1'b1;
                        state        <= st_write;
                    end
                end
                st_read: begin
                    if (mem_read_ready) begin
                        mem_read_en <= 1'b0;
                        load_done   <= 1'b1;       // Formatter has the data by now
                        state       <= st_idle;
                    end
                end
                st_write: begin
                    if (mem_write_ready) begin
                        mem_write_en <= 1'b0;
                        state        <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Bus and load context stay stable for the whole access
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr  <= req.addr;
            mem_wdata <= req.wdata;
            mem_strb  <= req.strb;
        end
        if (start && is_load) begin
            load_op     <= req.op;
            load_rd     <= req.rd;
            load_offset <= req.addr[1:0];
        end
    end

endmodule

`default_nettype wire

// File: hdl/ls_stage_reg.sv
// Pipeline stage register holding one item with a valid bit and stall hold
`timescale 1ns/100ps
`default_nettype none

module ls_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      in_valid,
    input  payload_t in_data,
    input  wire      advance,                      // Output consumed or stage empty
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;                 // Drops to zero when nothing arrives
        end
    end

    always_ff @(posedge clk) begin
        if (advance && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_pkg.sv
// Load/store unit shared types: operation codes, stage payloads and RV32I constants
`default_nettype none

package lsu_pkg;

    localparam int xlen = 32;                       // Data and address width

    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // funct3 encodings shared by loads and stores
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;          // Loads only
    localparam logic [2:0] f3_hu = 3'b101;          // Loads only

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lbu  = 4'd2,
        op_lh   = 4'd3,
        op_lhu  = 4'd4,
        op_lw   = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } ls_op_e;

    typedef enum logic [1:0] {
        size_word = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2
    } ls_size_e;

    typedef struct packed {
        ls_op_e            op;
        logic [4:0]        rd;
        logic [xlen-1:0]   rs1_data;
        logic [xlen-1:0]   rs2_data;
        logic [xlen-1:0]   imm;                    // Already sign-extended
    } dec_t;

    typedef struct packed {
        ls_op_e            op;
        logic [4:0]        rd;
        logic [xlen-1:0]   addr;
        logic [xlen/8-1:0] strb;
        logic [xlen-1:0]   wdata;                  // Store data in its byte lane
        logic              misaligned;             // Access must not reach the bus
    } agen_t;

    typedef struct packed {
        logic [4:0]        rd;
        logic [xlen-1:0]   data;
    } wb_t;

endpackage

`default_nettype wire

// File: hdl/lsu_top.sv
// Load/store unit top chaining decode, stage registers, address stage, controller, formatter
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         issue,
    input  wire [lsu_pkg::xlen-1:0]     instr,
    input  wire [lsu_pkg::xlen-1:0]     rs1_data,
    input  wire [lsu_pkg::xlen-1:0]     rs2_data,
    output logic                        issue_ready,
    output logic [lsu_pkg::xlen-1:0]    mem_addr,
    output logic [lsu_pkg::xlen-1:0]    mem_wdata,
    output logic [lsu_pkg::xlen/8-1:0]  mem_strb,
    output logic                        mem_read_en,
    output logic                        mem_write_en,
    input  wire [lsu_pkg::xlen-1:0]     mem_rdata,
    input  wire                         mem_read_ready,
    input  wire                         mem_write_ready,
    output lsu_pkg::wb_t                wb,
    output logic                        wb_en,
    output logic                        misalign
);
    import lsu_pkg::*;

    dec_t       dec;
    dec_t       a_data;
    logic       dec_valid;
    logic       a_valid;
    agen_t      agen;
    agen_t      b_data;
    logic       b_valid;
    logic       b_advance;
    logic       accept;
    logic       load_done;
    ls_op_e     load_op;
    logic [4:0] load_rd;
    logic [1:0] load_offset;

    ls_decode i_decode (
        .instr, .rs1_data, .rs2_data, .issue,
        .dec, .dec_valid
    );

    // Each register advances when empty or when the next stage takes its item
    assign b_advance   = !b_valid || accept;
    assign issue_ready = !a_valid || b_advance;

    ls_stage_reg #(.payload_t(dec_t)) i_dec_reg (
        .clk, .rst,
        .in_valid  (dec_valid), .in_data  (dec),
        .advance   (issue_ready),
        .out_valid (a_valid),   .out_data (a_data)
    );

    ls_agen i_agen (
        .dec        (a_data),
        .agen       (agen),
        .misaligned ()                             // Flag travels inside the agen payload
    );

    ls_stage_reg #(.payload_t(agen_t)) i_agen_reg (
        .clk, .rst,
        .in_valid  (a_valid), .in_data  (agen),
        .advance   (b_advance),
        .out_valid (b_valid), .out_data (b_data)
    );

    ls_mem_ctrl i_mem_ctrl (
        .clk, .rst,
        .req_valid (b_valid), .req (b_data), .req_misaligned (b_data.misaligned),
        .accept,
        .mem_addr, .mem_wdata, .mem_strb, .mem_read_en, .mem_write_en,
        .mem_read_ready, .mem_write_ready,
        .load_done, .load_op, .load_rd, .load_offset,
        .misalign
    );

    ls_load_format i_load_format (
        .clk, .rst,
        .load_done, .load_op, .load_rd, .load_offset,
        .mem_rdata, .mem_read_ready,
        .wb, .wb_en
    );

endmodule

`default_nettype wire
